// File: chien_bank/chien_pe.sv
`include "bch_config.svh"

module chien_pe #(
    parameter int PE_INDEX = 0
) (
    locator_if.pe  loc,
    output logic   o_is_root
);

    // exponents of alpha^-j and alpha^-2j, mod n
    localparam int EXP1 = (`BCH_N - PE_INDEX) % `BCH_N;
    localparam int EXP2 = (2 * `BCH_N - 2 * PE_INDEX) % `BCH_N;

    localparam gf_pkg::gf_elem_t ALPHA_N1 = gf_pkg::gf_alpha_pow(EXP1);
    localparam gf_pkg::gf_elem_t ALPHA_N2 = gf_pkg::gf_alpha_pow(EXP2);

    gf_pkg::gf_elem_t term1;
    gf_pkg::gf_elem_t term2;
    gf_pkg::gf_elem_t sum;

    // constant multipliers
    assign term1 = gf_pkg::gf_mul(loc.sigma1, ALPHA_N1);
    assign term2 = gf_pkg::gf_mul(loc.sigma2, ALPHA_N2);

    // sigma(alpha^-j)
    assign sum       = loc.sigma0 ^ term1 ^ term2;
    assign o_is_root = (sum == '0);

endmodule

// File: chien_bank/locator_loader.sv
module locator_loader (
    input  logic              i_clk,
    input  logic              i_rst_n,

    input  logic              i_valid,
    output logic              o_ready,
    input  gf_pkg::gf_elem_t  i_sigma0,
    input  gf_pkg::gf_elem_t  i_sigma1,
    input  gf_pkg::gf_elem_t  i_sigma2,

    locator_if.loader         loc
);

    logic                  accept;
    bch_pkg::bch_degree_t  degree_in;

    // slot free, or its item leaves this cycle
    assign o_ready = !loc.valid || loc.ready;
    assign accept  = i_valid && o_ready;

    // highest nonzero coefficient
    always_comb begin
        if (i_sigma2 != '0) begin
            degree_in = 2'd2;
        end
        else if (i_sigma1 != '0) begin
            degree_in = 2'd1;
        end
        else begin
            degree_in = 2'd0;
        end
    end

    // ------------------------------
    // slot valid
    // ------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            loc.valid <= 1'b0;
        end
        else if (accept) begin
            loc.valid <= 1'b1;
        end
        else if (loc.ready) begin
            loc.valid <= 1'b0; // taken by collector
        end
    end

    // captured locator
    always_ff @(posedge i_clk) begin
        if (accept) begin
            loc.sigma0 <= i_sigma0;
            loc.sigma1 <= i_sigma1;
            loc.sigma2 <= i_sigma2;
            loc.degree <= degree_in;
        end
    end

endmodule

// File: chien_bank/root_collector.sv
`include "bch_config.svh"

module root_collector (
    input  logic                  i_clk,
    input  logic                  i_rst_n,

    locator_if.collector          loc,
    input  logic [`BCH_N-1:0]     i_roots,

    output logic                  o_valid,
    input  logic                  i_ready,
    output bch_pkg::bch_count_t   o_num_err,
    output bch_pkg::bch_pos_t     o_err_loc0,
    output bch_pkg::bch_pos_t     o_err_loc1,
    output bch_pkg::bch_status_e  o_status
);

    logic                  take;
    bch_pkg::bch_count_t   cnt_c;
    bch_pkg::bch_pos_t     pos0_c;
    bch_pkg::bch_pos_t     pos1_c;
    bch_pkg::bch_status_e  status_c;

    // output register empty or draining
    assign loc.ready = !o_valid || i_ready;
    assign take      = loc.valid && loc.ready;

    // ------------------------------
    // root scan, lowest index first
    // ------------------------------
    always_comb begin
        cnt_c  = '0;
        pos0_c = '0;
        pos1_c = '0;
        for (int i = 0; i < `BCH_N; i++) begin
            if (i_roots[i]) begin
                if (cnt_c == 2'd0) begin
                    pos0_c = bch_pkg::bch_pos_t'(i);
                end
                else if (cnt_c == 2'd1) begin
                    pos1_c = bch_pkg::bch_pos_t'(i);
                end
                if (cnt_c != 2'd3) begin
                    cnt_c = cnt_c + 2'd1; // saturate at 3
                end
            end
        end
    end

    // count against locator degree
    always_comb begin
        if (loc.degree == 2'd0 && cnt_c == 2'd0) begin
            status_c = bch_pkg::STAT_CLEAN;
        end
        else if (loc.degree != 2'd0 && cnt_c == loc.degree) begin
            status_c = bch_pkg::STAT_CORRECTED;
        end
        else begin
            status_c = bch_pkg::STAT_FAILED;
        end
    end

    // ------------------------------
    // output register
    // ------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end
        else if (take) begin
            o_valid <= 1'b1;
        end
        else if (i_ready) begin
            o_valid <= 1'b0;
        end
    end

    // fields held while stalled
    always_ff @(posedge i_clk) begin
        if (take) begin
            o_num_err  <= cnt_c;
            o_err_loc0 <= pos0_c;
            o_err_loc1 <= pos1_c;
            o_status   <= status_c;
        end
    end

endmodule

// File: common/bch_config.svh
`ifndef BCH_CONFIG_SVH
`define BCH_CONFIG_SVH

// ------------------------------
// bch (63,51), t = 2
// ------------------------------

// GF(2^6) element width
`define BCH_M       6

// code length, also the number of search PEs
`define BCH_N       63

// correction capability
`define BCH_T       2

// x^6 + x + 1
`define BCH_POLY    7'b1000011

// width of an error position
`define BCH_IDX_W   6

`endif

// File: common/bch_pkg.sv
`include "bch_config.svh"

package bch_pkg;

    // error position, 0 to n-1
    typedef logic [`BCH_IDX_W-1:0] bch_pos_t;

    // roots found; all ones means more than t
    typedef logic [$clog2(`BCH_T+2)-1:0] bch_count_t;

    // locator degree, 0 to t
    typedef logic [$clog2(`BCH_T+1)-1:0] bch_degree_t;

    // ------------------------------
    // decode status
    // ------------------------------
    typedef enum logic [1:0] {
        STAT_CLEAN     = 2'd0, // degree 0, no roots
        STAT_CORRECTED = 2'd1, // root count matches degree
        STAT_FAILED    = 2'd2
    } bch_status_e;

endpackage

// File: common/gf_pkg.sv
`include "bch_config.svh"

package gf_pkg;

    typedef logic [`BCH_M-1:0] gf_elem_t;

    // ------------------------------
    // field arithmetic
    // ------------------------------

    // shift and add, reduced by the primitive polynomial each step
    function automatic gf_elem_t gf_mul(input gf_elem_t a, input gf_elem_t b);
        gf_elem_t prod;
        gf_elem_t sh;
        logic [`BCH_M:0] ext;
        prod = '0;
        sh   = a;
        for (int i = 0; i < `BCH_M; i++) begin
            if (b[i]) begin
                prod = prod ^ sh;
            end
            ext = {sh, 1'b0};
            if (ext[`BCH_M]) begin
                ext = ext ^ `BCH_POLY;
            end
            sh = ext[`BCH_M-1:0];
        end
        return prod;
    endfunction

    // alpha^k, k taken mod n
    function automatic gf_elem_t gf_alpha_pow(input int unsigned k);
        gf_elem_t r;
        r = gf_elem_t'(1);
        for (int i = 0; i < (k % `BCH_N); i++) begin
            r = gf_mul(r, gf_elem_t'(2)); // times alpha
        end
        return r;
    endfunction

endpackage

// File: common/locator_if.sv
// one captured locator, loader -> pe bank and collector
interface locator_if;

    logic                  valid;
    logic                  ready;
    gf_pkg::gf_elem_t      sigma0;
    gf_pkg::gf_elem_t      sigma1;
    gf_pkg::gf_elem_t      sigma2;
    bch_pkg::bch_degree_t  degree;

    modport loader (output valid, sigma0, sigma1, sigma2, degree, input ready);

    modport pe (input sigma0, sigma1, sigma2);

    modport collector (input valid, degree, output ready);

endinterface

// File: filelist.f
+incdir+common
common/gf_pkg.sv
common/bch_pkg.sv
common/locator_if.sv
chien_bank/locator_loader.sv
chien_bank/chien_pe.sv
chien_bank/root_collector.sv
hdl/chien_search.sv
tests/chien_sva.sv
tests/chien_checker.sv
tests/tb_chien_search.sv

// File: hdl/chien_search.sv
`include "bch_config.svh"

module chien_search (
    input  logic                  i_clk,
    input  logic                  i_rst_n,

    // locator in
    input  logic                  i_valid,
    output logic                  o_ready,
    input  gf_pkg::gf_elem_t      i_sigma0,
    input  gf_pkg::gf_elem_t      i_sigma1,
    input  gf_pkg::gf_elem_t      i_sigma2,

    // result out
    output logic                  o_valid,
    input  logic                  i_ready,
    output bch_pkg::bch_count_t   o_num_err,
    output bch_pkg::bch_pos_t     o_err_loc0,
    output bch_pkg::bch_pos_t     o_err_loc1,
    output bch_pkg::bch_status_e  o_status
);

    locator_if loc_bus ();

    logic [`BCH_N-1:0] roots; // one flag per tested alpha^-j

    locator_loader u_loader (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_valid  (i_valid),
        .o_ready  (o_ready),
        .i_sigma0 (i_sigma0),
        .i_sigma1 (i_sigma1),
        .i_sigma2 (i_sigma2),
        .loc      (loc_bus.loader)
    );

    // ------------------------------
    // pe bank, full field in one pass
    // ------------------------------
    genvar j;
    generate
        for (j = 0; j < `BCH_N; j = j + 1) begin : gen_pe
            chien_pe #(
                .PE_INDEX (j)
            ) u_pe (
                .loc       (loc_bus.pe),
                .o_is_root (roots[j])
            );
        end
    endgenerate

    root_collector u_collector (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .loc        (loc_bus.collector),
        .i_roots    (roots),
        .o_valid    (o_valid),
        .i_ready    (i_ready),
        .o_num_err  (o_num_err),
        .o_err_loc0 (o_err_loc0),
        .o_err_loc1 (o_err_loc1),
        .o_status   (o_status)
    );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_chien_search \
    -f filelist.f -o sim_chien \
    && ./obj_dir/sim_chien > sim.log 2>&1 \
    ; cat sim.log 2>/dev/null \
    ; grep -qx "TEST OK" sim.log && exit 0 || exit 1

// File: tests/chien_checker.sv
module chien_checker (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_valid,
    input  logic                  i_ready,
    input  bch_pkg::bch_count_t   i_num_err,
    input  bch_pkg::bch_pos_t     i_err_loc0,
    input  bch_pkg::bch_pos_t     i_err_loc1,
    input  bch_pkg::bch_status_e  i_status,
    output int                    o_checked,
    output int                    o_errors
);

    // record is {count, loc0, loc1, status}
    string        exp_name[$];
    logic [15:0]  exp_rec[$];
    string        name;
    logic [15:0]  want;
    logic [15:0]  got;

    task automatic expect_result(input string test_name, input logic [15:0] rec);
        exp_name.push_back(test_name);
        exp_rec.push_back(rec);
    endtask

    function automatic string format_result(input logic [15:0] r);
        return $sformatf("count=%0d loc0=%0d loc1=%0d status=%0d",
                         r[15:14], r[13:8], r[7:2], r[1:0]);
    endfunction

    always @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_checked = 0;
            o_errors  = 0;
        end
        else if (i_valid && i_ready) begin
            got = {i_num_err, i_err_loc0, i_err_loc1, i_status};
            if (exp_rec.size() == 0) begin
                $display("result came out with no test pending: %s", format_result(got));
                o_errors = o_errors + 1;
            end
            else begin
                name      = exp_name.pop_front();
                want      = exp_rec.pop_front();
                o_checked = o_checked + 1;
                if (got === want) begin
                    $display("ok  %s", name);
                end
                else begin
                    $display("ERR %s expected %s actual %s", name,
                             format_result(want), format_result(got));
                    o_errors = o_errors + 1;
                end
            end
        end
    end

endmodule

// File: tests/chien_stimulus.txt
# name  sigma0 sigma1 sigma2 (hex)  count loc0 loc1 status (decimal)
# status 0 clean, 1 corrected, 2 failed
two_3_10     01 38 0a  2  3 10 1
two_0_62     01 20 21  2  0 62 1
two_5_40     01 0f 19  2  5 40 1
two_20_21    01 07 1d  2 20 21 1
one_7        01 06 00  1  7  0 1
one_0        01 01 00  1  0  0 1
one_50       01 34 00  1 50  0 1
clean        01 00 00  0  0  0 0
irreducible  01 01 20  0  0  0 2
double_4     01 00 0c  1  4  0 2
no_root_d1   00 05 00  0  0  0 2
all_zero     00 00 00  3  0  1 2

// File: tests/chien_sva.sv
module chien_sva (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  o_ready,
    input  logic                  o_valid,
    input  logic                  i_ready,
    input  bch_pkg::bch_count_t   o_num_err,
    input  bch_pkg::bch_pos_t     o_err_loc0,
    input  bch_pkg::bch_pos_t     o_err_loc1,
    input  bch_pkg::bch_status_e  o_status
);

    // ------------------------------
    // output held while stalled
    // ------------------------------
    a_stall_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_valid && !i_ready |=> o_valid && $stable(o_num_err) && $stable(o_err_loc0)
            && $stable(o_err_loc1) && $stable(o_status))
        else $error("result changed or dropped while the sink stalled");

    a_rst_valid: assert property (@(posedge i_clk) !i_rst_n |=> !o_valid)
        else $error("o_valid high during reset");

    a_rst_ready: assert property (@(posedge i_clk) $rose(i_rst_n) |-> o_ready)
        else $error("o_ready low in the first cycle after reset");

endmodule

// File: tests/tb_chien_search.sv
module tb_chien_search;

    localparam int ACCEPT_LIMIT = 100;
    localparam int DRAIN_LIMIT  = 500;
    localparam int READY_CYCLES = 3000;

    logic                  clk;
    logic                  rst_n;
    logic                  in_valid;
    logic                  in_ready;
    gf_pkg::gf_elem_t      sigma0;
    gf_pkg::gf_elem_t      sigma1;
    gf_pkg::gf_elem_t      sigma2;
    logic                  out_valid;
    logic                  out_ready;
    bch_pkg::bch_count_t   num_err;
    bch_pkg::bch_pos_t     err_loc0;
    bch_pkg::bch_pos_t     err_loc1;
    bch_pkg::bch_status_e  status;

    int      checked;
    int      errors;
    int      sent;
    int      fields;
    int      waited;
    int      s0;
    int      s1;
    int      s2;
    int      cnt;
    int      l0;
    int      l1;
    int      st;
    logic    ok;
    logic    aborted;
    integer  seed;
    integer  fd;
    string   line;
    string   name;

    chien_search u_dut (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_valid    (in_valid),
        .o_ready    (in_ready),
        .i_sigma0   (sigma0),
        .i_sigma1   (sigma1),
        .i_sigma2   (sigma2),
        .o_valid    (out_valid),
        .i_ready    (out_ready),
        .o_num_err  (num_err),
        .o_err_loc0 (err_loc0),
        .o_err_loc1 (err_loc1),
        .o_status   (status)
    );

    chien_checker u_checker (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_valid    (out_valid),
        .i_ready    (out_ready),
        .i_num_err  (num_err),
        .i_err_loc0 (err_loc0),
        .i_err_loc1 (err_loc1),
        .i_status   (status),
        .o_checked  (checked),
        .o_errors   (errors)
    );

    bind chien_search chien_sva u_sva (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .o_ready    (o_ready),
        .o_valid    (o_valid),
        .i_ready    (i_ready),
        .o_num_err  (o_num_err),
        .o_err_loc0 (o_err_loc0),
        .o_err_loc1 (o_err_loc1),
        .o_status   (o_status)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // ------------------------------
    // random output back-pressure
    // ------------------------------
    initial begin
        out_ready = 1'b0;
        seed      = 32'hb6db9b53;
        repeat (READY_CYCLES) begin
            @(posedge clk);
            #2;
            out_ready = (($random(seed) & 3) != 0); // high about 3 cycles in 4
        end
        out_ready = 1'b1;
    end

    // hold one locator on the input until the loader takes it
    task automatic send_locator(input int a0, input int a1, input int a2, output logic taken);
        int tries;
        sigma0   = a0[5:0];
        sigma1   = a1[5:0];
        sigma2   = a2[5:0];
        in_valid = 1'b1;
        tries    = 0;
        taken    = 1'b0;
        while (!taken && tries < ACCEPT_LIMIT) begin
            @(posedge clk);
            taken = in_ready;
            tries = tries + 1;
        end
        #2;
    endtask

    initial begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        sigma0   = '0;
        sigma1   = '0;
        sigma2   = '0;
        sent     = 0;
        aborted  = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;

        fd = $fopen("tests/chien_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file tests/chien_stimulus.txt");
            aborted = 1'b1;
        end
        else begin
            while (!aborted && $fgets(line, fd) != 0) begin
                fields = $sscanf(line, "%s %h %h %h %d %d %d %d",
                                 name, s0, s1, s2, cnt, l0, l1, st);
                if (line.getc(0) != "#" && fields == 8) begin
                    u_checker.expect_result(name, {cnt[1:0], l0[5:0], l1[5:0], st[1:0]});
                    send_locator(s0, s1, s2, ok);
                    if (ok) begin
                        sent = sent + 1;
                    end
                    else begin
                        $display("timeout: locator %s was never accepted", name);
                        aborted = 1'b1;
                    end
                end
            end
            $fclose(fd);
        end
        in_valid = 1'b0;

        // drain whatever is still in flight
        waited = 0;
        while (checked < sent && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited = waited + 1;
        end
        if (checked < sent) begin
            $display("timeout: %0d results never came out", sent - checked);
            aborted = 1'b1;
        end
        repeat (5) @(posedge clk); // catch stray output transfers

        $display("sent %0d, checked %0d, errors %0d", sent, checked, errors);
        if (!aborted && errors == 0 && sent > 0 && checked == sent) begin
            $display("TEST OK");
        end
        else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
